// ==== design/rename_pkg.sv ====
// shared sizes, tag types and port structs for the rename stage, compiled ahead of all RTL
`default_nettype none

package rename_pkg;

	localparam int arf_size = 8; // architectural regs
	localparam int prf_size = 16; // physical regs

	typedef logic [$clog2(arf_size)-1:0] arch_idx_t; // 3 bit arch index
	typedef logic [$clog2(prf_size)-1:0] phys_tag_t; // 4 bit phys tag
	typedef phys_tag_t [arf_size-1:0] map_table_t; // one tag per arch reg
	typedef logic [prf_size-1:0] free_vec_t; // set bit = tag free

	typedef struct packed {
		logic valid; // instruction present
		arch_idx_t src_a; // first source
		arch_idx_t src_b; // second source
		logic dest_valid; // writes a register
		arch_idx_t dest; // destination
	} rename_req_t;

	typedef struct packed {
		logic valid; // result present
		phys_tag_t src_a_tag; // mapped first source
		phys_tag_t src_b_tag; // mapped second source
		logic dest_valid; // dest renamed
		phys_tag_t dest_tag; // fresh tag
		phys_tag_t old_tag; // displaced tag
	} rename_rsp_t;

	typedef struct packed {
		logic valid; // commit strobe
		arch_idx_t arch; // committed arch reg
		phys_tag_t tag; // its tag
	} commit_t;

	// reset contents of both map tables, arch reg i sits on phys tag i
	function automatic map_table_t identity_map();
		map_table_t m;
		for (int i = 0; i < arf_size; i++) begin
			m[i] = phys_tag_t'(i);
		end
		return m;
	endfunction

endpackage

`default_nettype wire

// ==== design/free_list.sv ====
// free physical tag bitmap feeding the rat, refilled on commit and rebuilt on mispredict
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input wire clock,
	input wire reset,
	input wire alloc_take, // rat consumed alloc_tag
	output rename_pkg::phys_tag_t alloc_tag, // lowest free tag
	output logic alloc_empty, // nothing left to hand out
	input wire rename_pkg::commit_t release_info, // tag freed by commit
	input wire rename_pkg::map_table_t committed_map, // rrat contents
	input wire mispredict // rebuild request
);

	rename_pkg::free_vec_t free_vec; // current free bits
	rename_pkg::free_vec_t rebuild_vec; // complement of rrat tags
	rename_pkg::free_vec_t next_vec; // value for next edge

	////////////////////////////////////////
	// lowest-first pick
	////////////////////////////////////////

	always_comb begin
		alloc_tag = '0;
		for (int i = rename_pkg::prf_size - 1; i >= 0; i--) begin // walk down, lowest wins
			if (free_vec[i]) begin
				alloc_tag = rename_pkg::phys_tag_t'(i);
			end
		end
		alloc_empty = ~|free_vec; // no bit set
	end

	////////////////////////////////////////
	// next free vector
	////////////////////////////////////////

	// every tag the committed map does not name is free after a mispredict
	always_comb begin
		rebuild_vec = '1;
		for (int i = 0; i < rename_pkg::arf_size; i++) begin
			rebuild_vec[committed_map[i]] = 1'b0; // held by rrat
		end
	end

	always_comb begin
		next_vec = free_vec;
		if (mispredict) begin
			next_vec = rebuild_vec; // speculative allocations discarded
		end else begin
			if (alloc_take) begin
				next_vec[alloc_tag] = 1'b0; // handed to rat
			end
			if (release_info.valid) begin
				next_vec[release_info.tag] = 1'b1; // back from rrat
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			free_vec <= {{(rename_pkg::prf_size - rename_pkg::arf_size){1'b1}},
				{rename_pkg::arf_size{1'b0}}}; // upper tags free, lower mapped
		end else begin
			free_vec <= next_vec;
		end
	end

endmodule

`default_nettype wire

// ==== design/rat.sv ====
// speculative register alias table, renames one instruction per cycle and stalls when tags run out
`timescale 1ns/1ps
`default_nettype none

module rat (
	input wire clock,
	input wire reset,
	input wire rename_pkg::rename_req_t req, // from decode
	input wire mispredict, // restore strobe
	input wire rename_pkg::map_table_t committed_map, // rrat copy
	input wire rename_pkg::phys_tag_t alloc_tag, // offered free tag
	input wire alloc_empty, // free list dry
	output logic alloc_take, // consume alloc_tag
	output logic rename_halt, // stall upstream
	output rename_pkg::rename_rsp_t rsp // registered result
);

	rename_pkg::map_table_t spec_map; // speculative mappings
	logic accept; // request taken this cycle

	////////////////////////////////////////
	// acceptance and halt
	////////////////////////////////////////

	always_comb begin
		rename_halt = req.valid & req.dest_valid & alloc_empty; // dest needs a tag, none left
		accept = req.valid & ~rename_halt & ~mispredict; // mispredict drops the request
		alloc_take = accept & req.dest_valid; // no dest, free list untouched
	end

	////////////////////////////////////////
	// map table and response
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			spec_map <= rename_pkg::identity_map(); // reg i on tag i
			rsp <= '0;
		end else if (mispredict) begin
			spec_map <= committed_map; // back to committed state
			rsp.valid <= 1'b0; // squashed
		end else begin
			rsp.valid <= accept;
			if (accept) begin
				// sources read the table ahead of this cycle's write
				rsp.src_a_tag <= spec_map[req.src_a];
				rsp.src_b_tag <= spec_map[req.src_b];
				rsp.dest_valid <= req.dest_valid;
				if (req.dest_valid) begin
					rsp.dest_tag <= alloc_tag; // fresh tag
					rsp.old_tag <= spec_map[req.dest]; // displaced mapping
				end else begin
					rsp.dest_tag <= '0;
					rsp.old_tag <= '0;
				end
			end
			if (alloc_take) begin
				spec_map[req.dest] <= alloc_tag; // remap dest
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/rrat.sv ====
// retirement alias table, tracks committed mappings and hands displaced tags to the free list
`timescale 1ns/1ps
`default_nettype none

module rrat (
	input wire clock,
	input wire reset,
	input wire rename_pkg::commit_t commit, // in-order commit from rob
	output rename_pkg::map_table_t committed_map, // restore and rebuild source
	output rename_pkg::commit_t release_info // tag to free, same cycle
);

	rename_pkg::map_table_t commit_map; // committed mappings

	////////////////////////////////////////
	// displaced tag
	////////////////////////////////////////

	// old entry goes out combinationally so the free list sets it at the commit edge
	always_comb begin
		release_info.valid = commit.valid;
		release_info.arch = commit.arch;
		release_info.tag = commit_map[commit.arch]; // tag being overwritten
	end

	assign committed_map = commit_map; // straight view of the table

	////////////////////////////////////////
	// table update
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_map <= rename_pkg::identity_map(); // same start as rat
		end else if (commit.valid) begin
			commit_map[commit.arch] <= commit.tag; // record new mapping
		end
	end

endmodule

`default_nettype wire

// ==== design/rename_stage.sv ====
// rename stage top, joins the rat, rrat and free list behind the request, commit and flush ports
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
	input wire clock,
	input wire reset,
	input wire rename_pkg::rename_req_t req, // rename request
	input wire rename_pkg::commit_t commit, // from rob
	input wire mispredict, // branch flush
	output rename_pkg::rename_rsp_t rsp, // rename result
	output logic rename_halt // stall level
);

	logic alloc_take; // rat took a tag
	rename_pkg::phys_tag_t alloc_tag; // lowest free tag
	logic alloc_empty; // free list dry
	rename_pkg::map_table_t committed_map; // rrat contents
	rename_pkg::commit_t release_info; // freed tag on commit

	////////////////////////////////////////
	// speculative side
	////////////////////////////////////////

	rat u_rat (
		.clock(clock),
		.reset(reset),
		.req(req),
		.mispredict(mispredict),
		.committed_map(committed_map),
		.alloc_tag(alloc_tag),
		.alloc_empty(alloc_empty),
		.alloc_take(alloc_take),
		.rename_halt(rename_halt),
		.rsp(rsp)
	);

	free_list u_free_list (
		.clock(clock),
		.reset(reset),
		.alloc_take(alloc_take),
		.alloc_tag(alloc_tag),
		.alloc_empty(alloc_empty),
		.release_info(release_info),
		.committed_map(committed_map),
		.mispredict(mispredict)
	);

	////////////////////////////////////////
	// committed side
	////////////////////////////////////////

	rrat u_rrat (
		.clock(clock),
		.reset(reset),
		.commit(commit),
		.committed_map(committed_map),
		.release_info(release_info)
	);

endmodule

`default_nettype wire

// ==== verification/rename_tb.sv ====
// testbench for the rename stage, replays the cycle table in rename_input.txt and checks each result
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

	// one table row, inputs for a cycle plus what must come back
	typedef struct packed {
		logic [7:0] op; // R C M or I
		rename_pkg::rename_req_t req; // request driven this cycle
		rename_pkg::commit_t commit; // commit driven this cycle
		rename_pkg::rename_rsp_t exp_rsp; // rsp after the edge
		logic exp_halt; // halt during the cycle
	} step_t;

	logic clock;
	logic reset;
	rename_pkg::rename_req_t req;
	rename_pkg::commit_t commit;
	logic mispredict;
	rename_pkg::rename_rsp_t rsp;
	logic rename_halt;

	step_t steps[$]; // whole table, loaded before reset ends
	int timeout_limit; // rows plus slack
	int cycle_count; // cycles since reset

	rename_stage u_dut (
		.clock(clock),
		.reset(reset),
		.req(req),
		.commit(commit),
		.mispredict(mispredict),
		.rsp(rsp),
		.rename_halt(rename_halt)
	);

	always #50 clock = ~clock; // 100 ns period

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// other fields are only meaningful when valid, tags only with a dest
	task automatic check_rsp(input rename_pkg::rename_rsp_t exp);
		check_value("rsp.valid", rsp.valid, exp.valid);
		if (exp.valid) begin
			check_value("rsp.src_a_tag", rsp.src_a_tag, exp.src_a_tag);
			check_value("rsp.src_b_tag", rsp.src_b_tag, exp.src_b_tag);
			check_value("rsp.dest_valid", rsp.dest_valid, exp.dest_valid);
			if (exp.dest_valid) begin
				check_value("rsp.dest_tag", rsp.dest_tag, exp.dest_tag);
				check_value("rsp.old_tag", rsp.old_tag, exp.old_tag);
			end
		end
	endtask

	////////////////////////////////////////
	// table loading
	////////////////////////////////////////

	task automatic load_steps();
		int fd;
		int code;
		int count;
		string line;
		logic [7:0] op_char;
		int a, b, dv, d;
		int ev, esa, esb, edv, edt, eot, eh;
		step_t s;
		fd = $fopen("verification/rename_input.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/rename_input.txt");
			$display("TESTS FAILED");
			$fatal(1, "missing stimulus file");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code != 0 && line.len() > 1 && line[0] != "#") begin // skip header, blanks
					count = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h", op_char,
						a, b, dv, d, ev, esa, esb, edv, edt, eot, eh);
					if (count != 12) begin
						$display("malformed line in stimulus file: %s", line);
						$display("TESTS FAILED");
						$fatal(1, "bad stimulus line");
					end else if (op_char != "R" && op_char != "C" && op_char != "M"
						&& op_char != "I") begin
						$display("unknown operation letter in stimulus file: %s", line);
						$display("TESTS FAILED");
						$fatal(1, "bad stimulus op");
					end else begin
						s = '0;
						s.op = op_char;
						if (op_char == "R" || op_char == "M") begin // mispredict carries a request
							s.req.valid = 1'b1;
							s.req.src_a = rename_pkg::arch_idx_t'(a);
							s.req.src_b = rename_pkg::arch_idx_t'(b);
							s.req.dest_valid = dv[0];
							s.req.dest = rename_pkg::arch_idx_t'(d);
						end
						if (op_char == "C") begin
							s.commit.valid = 1'b1;
							s.commit.arch = rename_pkg::arch_idx_t'(a); // a column is arch
							s.commit.tag = rename_pkg::phys_tag_t'(b); // b column is tag
						end
						s.exp_rsp.valid = ev[0];
						s.exp_rsp.src_a_tag = rename_pkg::phys_tag_t'(esa);
						s.exp_rsp.src_b_tag = rename_pkg::phys_tag_t'(esb);
						s.exp_rsp.dest_valid = edv[0];
						s.exp_rsp.dest_tag = rename_pkg::phys_tag_t'(edt);
						s.exp_rsp.old_tag = rename_pkg::phys_tag_t'(eot);
						s.exp_halt = eh[0];
						steps.push_back(s);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_step(input step_t s);
		req = s.req;
		commit = s.commit;
		mispredict = (s.op == "M"); // one cycle pulse
	endtask

	////////////////////////////////////////
	// run
	////////////////////////////////////////

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		req = '0;
		commit = '0;
		mispredict = 1'b0;
		cycle_count = 0;
		load_steps();
		timeout_limit = steps.size() + 20;
		repeat (2) @(posedge clock); // two reset cycles
		#1 reset = 1'b0;
		for (int k = 0; k < steps.size(); k++) begin
			if (k > 0) begin
				check_rsp(steps[k - 1].exp_rsp); // result of last row's request
			end
			drive_step(steps[k]);
			@(negedge clock); // halt settled mid cycle
			check_value("rename_halt", rename_halt, steps[k].exp_halt);
			@(posedge clock);
			#1;
		end
		check_rsp(steps[steps.size() - 1].exp_rsp);
		$display("TESTS PASSED");
		$finish;
	end

	// guard against a stalled run
	always @(posedge clock) begin
		if (!reset) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count > timeout_limit) begin
				$display("run did not finish within %0d cycles", timeout_limit);
				$display("TESTS FAILED");
				$fatal(1, "timeout");
			end
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/rename_pkg.sv
design/free_list.sv
design/rat.sv
design/rrat.sv
design/rename_stage.sv
verification/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - files:
      - design/rename_pkg.sv
      - design/free_list.sv
      - design/rat.sv
      - design/rrat.sv
      - design/rename_stage.sv
  - target: test
    files:
      - verification/rename_tb.sv

// ==== verification/rename_input.txt ====
# op a b dv d | rsp after edge: valid src_a_tag src_b_tag dest_valid dest_tag old_tag | halt
# hex values; C uses a as arch and b as tag, M also drives the request in a..d
I 0 0 0 0 0 0 0 0 0 0 0
R 1 2 1 3 1 1 2 1 8 3 0
R 3 3 1 3 1 8 8 1 9 8 0
R 0 3 1 0 1 0 9 1 a 0 0
R 1 0 1 1 1 1 a 1 b 1 0
R 2 2 1 2 1 2 2 1 c 2 0
R 4 5 1 4 1 4 5 1 d 4 0
R 5 4 1 5 1 5 d 1 e 5 0
R 6 7 1 6 1 6 7 1 f 6 0
R 7 6 0 0 1 7 f 0 0 0 0
R 7 6 1 7 0 0 0 0 0 0 1
R 7 6 1 7 0 0 0 0 0 0 1
C 3 8 0 0 0 0 0 0 0 0 0
R 7 6 1 7 1 7 f 1 3 7 0
R 0 1 1 2 0 0 0 0 0 0 1
C 3 9 0 0 0 0 0 0 0 0 0
C 0 a 0 0 0 0 0 0 0 0 0
R 0 3 1 2 1 a 9 1 0 c 0
M 1 2 1 1 0 0 0 0 0 0 0
R 0 3 1 4 1 a 9 1 0 4 0
R 2 7 1 5 1 2 7 1 3 5 0
R 4 5 0 0 1 0 3 0 0 0 0
M 4 4 0 0 0 0 0 0 0 0 0
R 4 5 1 6 1 4 5 1 0 6 0
R 6 6 1 6 1 0 0 1 3 0 0
I 0 0 0 0 0 0 0 0 0 0 0
